// ==== Makefile ====
TOP = tb_ahb_subsys
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module ahb_subsys

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
+incdir+common
common/soc_pkg.sv
sram/ahb_sram.sv
periph/apb_bridge.sv
periph/apb_gpio.sv
hdl/ahb_decoder.sv
hdl/ahb_subsys.sv
verif/tb_ahb_subsys.sv

// ==== common/soc_cfg.svh ====
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define APB_ADDR_W 4

// SRAM size in 32-bit words
`define SRAM_DEPTH 1024

// Memory map, inclusive end addresses
`define SRAM_BASE 32'h0000_0000
`define SRAM_END  32'h0000_0FFF
`define GPIO_BASE 32'h1000_0000
`define GPIO_END  32'h1000_000F

`define GPIO_W 32

`endif

// ==== common/soc_pkg.sv ====
package soc_pkg;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // Owner of the current AHB data phase
  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_SRAM,
    SEL_PERIPH
  } slave_sel_t;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_SETUP,
    BR_ACCESS,
    BR_ERROR
  } bridge_state_t;

  // Word offsets, byte addresses 0x0, 0x4 and 0x8
  typedef enum logic [1:0] {
    REG_OUT = 2'd0,
    REG_DIR = 2'd1,
    REG_IN  = 2'd2
  } gpio_reg_t;

endpackage

// ==== hdl/ahb_decoder.sv ====
`include "soc_cfg.svh"

module ahb_decoder (
  input  logic                   core_clk_i,
  input  logic                   reset_n_i,
  input  logic [`SOC_ADDR_W-1:0] haddr_i,
  input  soc_pkg::htrans_t       htrans_i,
  input  logic                   hready_i,
  output logic                   sram_sel_o,
  output logic                   periph_sel_o,
  input  logic [`SOC_DATA_W-1:0] sram_rdata_i,
  input  logic [`SOC_DATA_W-1:0] periph_rdata_i,
  input  logic                   periph_ready_i,
  input  logic                   periph_resp_i,
  output logic [`SOC_DATA_W-1:0] hrdata_o,
  output logic                   hready_o,
  output logic                   hresp_o
);

  // mask = ~(end - base)
  localparam logic [`SOC_ADDR_W-1:0] SRAM_MASK = ~(`SRAM_END - `SRAM_BASE);
  localparam logic [`SOC_ADDR_W-1:0] GPIO_MASK = ~(`GPIO_END - `GPIO_BASE);

  logic                trans_valid;
  logic                sram_hit;
  logic                periph_hit;
  soc_pkg::slave_sel_t data_sel;
  logic                err_first;
  logic                err_last;

  assign trans_valid = hready_i &&
                       (htrans_i == soc_pkg::NONSEQ || htrans_i == soc_pkg::SEQ);
  assign sram_hit    = (haddr_i & SRAM_MASK) == (`SRAM_BASE & SRAM_MASK);
  assign periph_hit  = (haddr_i & GPIO_MASK) == (`GPIO_BASE & GPIO_MASK);

  assign sram_sel_o   = trans_valid && sram_hit;
  assign periph_sel_o = trans_valid && periph_hit;

  always_ff @(posedge core_clk_i or negedge reset_n_i) begin
    if (!reset_n_i) begin
      data_sel  <= soc_pkg::SEL_NONE;
      err_first <= 1'b0;
      err_last  <= 1'b0;
    end else begin
      err_last <= err_first;
      if (hready_i) begin
        if (sram_sel_o) begin
          data_sel <= soc_pkg::SEL_SRAM;
        end else if (periph_sel_o) begin
          data_sel <= soc_pkg::SEL_PERIPH;
        end else begin
          data_sel <= soc_pkg::SEL_NONE;
        end
        // Unmapped but valid transfer
        err_first <= trans_valid && !sram_hit && !periph_hit;
      end else begin
        err_first <= 1'b0;
      end
    end
  end

  always_comb begin
    case (data_sel)
      soc_pkg::SEL_SRAM: begin
        hrdata_o = sram_rdata_i;
        hready_o = 1'b1;
        hresp_o  = 1'b0;
      end
      soc_pkg::SEL_PERIPH: begin
        hrdata_o = periph_rdata_i;
        hready_o = periph_ready_i;
        hresp_o  = periph_resp_i;
      end
      default: begin
        hrdata_o = '0;
        hready_o = !err_first;
        hresp_o  = err_first || err_last;
      end
    endcase
  end

  // Error must take two cycles, whichever slave raised it
  a_err_two_cycle: assert property (
    @(posedge core_clk_i) disable iff (!reset_n_i)
      (hresp_o && hready_o) |-> $past(hresp_o && !hready_o)
  ) else $error("error response without its first cycle");

endmodule

// ==== hdl/ahb_subsys.sv ====
`include "soc_cfg.svh"

module ahb_subsys (
  input  logic                   core_clk,
  input  logic                   reset_n,
  input  logic [`SOC_ADDR_W-1:0] haddr_i,
  input  soc_pkg::htrans_t       htrans_i,
  input  logic                   hwrite_i,
  input  logic [`SOC_DATA_W-1:0] hwdata_i,
  output logic [`SOC_DATA_W-1:0] hrdata_o,
  output logic                   hready_o,
  output logic                   hresp_o,
  input  logic [`GPIO_W-1:0]     gpio_in_i,
  output logic [`GPIO_W-1:0]     gpio_out_o,
  output logic [`GPIO_W-1:0]     gpio_oe_o
);

  logic                   sram_sel;
  logic                   periph_sel;
  logic [`SOC_DATA_W-1:0] sram_rdata;
  logic [`SOC_DATA_W-1:0] periph_rdata;
  logic                   periph_ready;
  logic                   periph_resp;

  // APB side of the bridge
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`APB_ADDR_W-1:0] paddr;
  logic [`SOC_DATA_W-1:0] pwdata;
  logic [`SOC_DATA_W-1:0] prdata;
  logic                   pslverr;

  ahb_decoder u_decoder (
    .core_clk_i     (core_clk),
    .reset_n_i      (reset_n),
    .haddr_i        (haddr_i),
    .htrans_i       (htrans_i),
    .hready_i       (hready_o),
    .sram_sel_o     (sram_sel),
    .periph_sel_o   (periph_sel),
    .sram_rdata_i   (sram_rdata),
    .periph_rdata_i (periph_rdata),
    .periph_ready_i (periph_ready),
    .periph_resp_i  (periph_resp),
    .hrdata_o       (hrdata_o),
    .hready_o       (hready_o),
    .hresp_o        (hresp_o)
  );

  ahb_sram u_sram (
    .core_clk_i (core_clk),
    .sel_i      (sram_sel),
    .haddr_i    (haddr_i),
    .hwrite_i   (hwrite_i),
    .hwdata_i   (hwdata_i),
    .rdata_o    (sram_rdata)
  );

  // Only the low offset bits reach the APB side
  apb_bridge u_bridge (
    .core_clk_i (core_clk),
    .reset_n_i  (reset_n),
    .sel_i      (periph_sel),
    .haddr_i    (haddr_i[`APB_ADDR_W-1:0]),
    .hwrite_i   (hwrite_i),
    .hwdata_i   (hwdata_i),
    .rdata_o    (periph_rdata),
    .ready_o    (periph_ready),
    .resp_o     (periph_resp),
    .psel_o     (psel),
    .penable_o  (penable),
    .pwrite_o   (pwrite),
    .paddr_o    (paddr),
    .pwdata_o   (pwdata),
    .prdata_i   (prdata),
    .pslverr_i  (pslverr)
  );

  apb_gpio u_gpio (
    .core_clk_i (core_clk),
    .reset_n_i  (reset_n),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .paddr_i    (paddr),
    .pwdata_i   (pwdata),
    .prdata_o   (prdata),
    .pslverr_o  (pslverr),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o)
  );

endmodule

// ==== periph/apb_bridge.sv ====
`include "soc_cfg.svh"

module apb_bridge (
  input  logic                   core_clk_i,
  input  logic                   reset_n_i,
  input  logic                   sel_i,
  input  logic [`APB_ADDR_W-1:0] haddr_i,
  input  logic                   hwrite_i,
  input  logic [`SOC_DATA_W-1:0] hwdata_i,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic                   ready_o,
  output logic                   resp_o,
  output logic                   psel_o,
  output logic                   penable_o,
  output logic                   pwrite_o,
  output logic [`APB_ADDR_W-1:0] paddr_o,
  output logic [`SOC_DATA_W-1:0] pwdata_o,
  input  logic [`SOC_DATA_W-1:0] prdata_i,
  input  logic                   pslverr_i
);

  soc_pkg::bridge_state_t state;
  soc_pkg::bridge_state_t state_nxt;
  logic [`APB_ADDR_W-1:0] addr_q;
  logic                   write_q;

  always_comb begin
    state_nxt = state;
    case (state)
      soc_pkg::BR_IDLE: begin
        if (sel_i) state_nxt = soc_pkg::BR_SETUP;
      end
      soc_pkg::BR_SETUP: state_nxt = soc_pkg::BR_ACCESS;
      soc_pkg::BR_ACCESS: begin
        if (pslverr_i) begin
          state_nxt = soc_pkg::BR_ERROR;
        end else if (sel_i) begin
          state_nxt = soc_pkg::BR_SETUP;
        end else begin
          state_nxt = soc_pkg::BR_IDLE;
        end
      end
      default: state_nxt = sel_i ? soc_pkg::BR_SETUP : soc_pkg::BR_IDLE;
    endcase
  end

  always_ff @(posedge core_clk_i or negedge reset_n_i) begin
    if (!reset_n_i) begin
      state <= soc_pkg::BR_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (sel_i) begin
      addr_q  <= haddr_i;
      write_q <= hwrite_i;
    end
  end

  assign psel_o    = (state == soc_pkg::BR_SETUP) || (state == soc_pkg::BR_ACCESS);
  assign penable_o = (state == soc_pkg::BR_ACCESS);
  assign pwrite_o  = write_q;
  assign paddr_o   = addr_q;
  // Master holds HWDATA until the data phase ends
  assign pwdata_o  = hwdata_i;
  assign rdata_o   = prdata_i;

  // Stall in setup, and in access when the slave flags an error
  assign ready_o = !((state == soc_pkg::BR_SETUP) ||
                     (state == soc_pkg::BR_ACCESS && pslverr_i));
  assign resp_o  = (state == soc_pkg::BR_ERROR) ||
                   (state == soc_pkg::BR_ACCESS && pslverr_i);

  a_apb_setup_first: assert property (
    @(posedge core_clk_i) disable iff (!reset_n_i)
      $rose(penable_o) |-> $past(psel_o && !penable_o)
  ) else $error("PENABLE without a setup cycle");

endmodule

// ==== periph/apb_gpio.sv ====
`include "soc_cfg.svh"

module apb_gpio (
  input  logic                   core_clk_i,
  input  logic                   reset_n_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic [`SOC_DATA_W-1:0] pwdata_i,
  output logic [`SOC_DATA_W-1:0] prdata_o,
  output logic                   pslverr_o,
  input  logic [`GPIO_W-1:0]     gpio_in_i,
  output logic [`GPIO_W-1:0]     gpio_out_o,
  output logic [`GPIO_W-1:0]     gpio_oe_o
);

  soc_pkg::gpio_reg_t reg_sel;
  logic               access;
  logic               bad_offset;
  logic               wr_en;
  logic [`GPIO_W-1:0] out_q;
  logic [`GPIO_W-1:0] dir_q;
  logic [`GPIO_W-1:0] in_meta;
  logic [`GPIO_W-1:0] in_sync;

  assign reg_sel    = soc_pkg::gpio_reg_t'(paddr_i[`APB_ADDR_W-1:2]);
  assign access     = psel_i && penable_i;
  // Misaligned or past the last register
  assign bad_offset = (paddr_i[1:0] != 2'b00) ||
                      !(reg_sel inside {soc_pkg::REG_OUT, soc_pkg::REG_DIR, soc_pkg::REG_IN});

  assign pslverr_o = access && (bad_offset || (pwrite_i && reg_sel == soc_pkg::REG_IN));
  assign wr_en     = access && pwrite_i && !pslverr_o;

  always_ff @(posedge core_clk_i or negedge reset_n_i) begin
    if (!reset_n_i) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (wr_en) begin
      if (reg_sel == soc_pkg::REG_OUT) out_q <= pwdata_i[`GPIO_W-1:0];
      if (reg_sel == soc_pkg::REG_DIR) dir_q <= pwdata_i[`GPIO_W-1:0];
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge core_clk_i or negedge reset_n_i) begin
    if (!reset_n_i) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= gpio_in_i;
      in_sync <= in_meta;
    end
  end

  always_comb begin
    case (reg_sel)
      soc_pkg::REG_OUT: prdata_o = out_q;
      soc_pkg::REG_DIR: prdata_o = dir_q;
      soc_pkg::REG_IN:  prdata_o = in_sync;
      default:          prdata_o = '0;
    endcase
  end

  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;

endmodule

// ==== sram/ahb_sram.sv ====
`include "soc_cfg.svh"

module ahb_sram (
  input  logic                   core_clk_i,
  input  logic                   sel_i,
  input  logic [`SOC_ADDR_W-1:0] haddr_i,
  input  logic                   hwrite_i,
  input  logic [`SOC_DATA_W-1:0] hwdata_i,
  output logic [`SOC_DATA_W-1:0] rdata_o
);

  localparam int IDX_W = $clog2(`SRAM_DEPTH);

  logic [`SOC_DATA_W-1:0] mem [`SRAM_DEPTH];
  logic [IDX_W-1:0]       idx_q;
  logic                   wr_q;

  // Address phase
  always_ff @(posedge core_clk_i) begin
    wr_q <= sel_i && hwrite_i;
    if (sel_i) begin
      idx_q <= haddr_i[IDX_W+1:2];
    end
  end

  // Write data arrives during the data phase
  always_ff @(posedge core_clk_i) begin
    if (wr_q) begin
      mem[idx_q] <= hwdata_i;
    end
  end

  assign rdata_o = mem[idx_q];

  // The decoder window and the array depth have to agree
  a_in_range: assert property (
    @(posedge core_clk_i)
      sel_i |-> ((haddr_i - `SRAM_BASE) < (`SRAM_DEPTH * 4))
  ) else $error("SRAM select outside the array");

endmodule

// ==== verif/tb_ahb_subsys.sv ====
`include "soc_cfg.svh"

module tb_ahb_subsys;

  localparam int WAIT_LIMIT = 50;
  localparam int SRAM_WRITES = 16;

  logic                   core_clk;
  logic                   reset_n;
  logic [`SOC_ADDR_W-1:0] haddr_i;
  soc_pkg::htrans_t       htrans_i;
  logic                   hwrite_i;
  logic [`SOC_DATA_W-1:0] hwdata_i;
  logic [`SOC_DATA_W-1:0] hrdata_o;
  logic                   hready_o;
  logic                   hresp_o;
  logic [`GPIO_W-1:0]     gpio_in_i;
  logic [`GPIO_W-1:0]     gpio_out_o;
  logic [`GPIO_W-1:0]     gpio_oe_o;

  // Expected SRAM contents
  logic [`SOC_DATA_W-1:0] sram_model [`SRAM_DEPTH];
  int unsigned            last_idx;
  int unsigned            seed;

  ahb_subsys uut (
    .core_clk   (core_clk),
    .reset_n    (reset_n),
    .haddr_i    (haddr_i),
    .htrans_i   (htrans_i),
    .hwrite_i   (hwrite_i),
    .hwdata_i   (hwdata_i),
    .hrdata_o   (hrdata_o),
    .hready_o   (hready_o),
    .hresp_o    (hresp_o),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o)
  );

  initial begin
    core_clk = 1'b0;
    forever #10 core_clk = ~core_clk;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s is 0x%08h, expected 0x%08h", $time, name, actual, expected);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Finished with errors");
    $fatal(1, "timeout");
  endtask

  // Runs to the edge that ends the current bus cycle, sampling at mid cycle
  task automatic wait_ready_edge(output logic resp, output logic [31:0] rdata,
                                 output int stalls);
    stalls = 0;
    @(negedge core_clk);
    while (!hready_o) begin
      stalls++;
      if (stalls > WAIT_LIMIT) begin
        report_timeout("hready_o stuck low");
      end else begin
        @(negedge core_clk);
      end
    end
    resp  = hresp_o;
    rdata = hrdata_o;
    @(posedge core_clk);
    #1;
  endtask

  task automatic drive_address(input logic [31:0] addr, input logic write);
    haddr_i  = addr;
    htrans_i = soc_pkg::NONSEQ;
    hwrite_i = write;
  endtask

  task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data,
                           output logic resp, output int stalls);
    logic [31:0] unused_rd;
    drive_address(addr, 1'b1);
    wait_ready_edge(resp, unused_rd, stalls);
    htrans_i = soc_pkg::IDLE;
    hwdata_i = data;
    wait_ready_edge(resp, unused_rd, stalls);
  endtask

  task automatic ahb_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output logic resp, output int stalls);
    drive_address(addr, 1'b0);
    wait_ready_edge(resp, rdata, stalls);
    htrans_i = soc_pkg::IDLE;
    wait_ready_edge(resp, rdata, stalls);
  endtask

  // Read address phase overlaps the write data phase
  task automatic write_read_pipelined(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        resp;
    int          stalls;
    drive_address(addr, 1'b1);
    wait_ready_edge(resp, rdata, stalls);
    drive_address(addr, 1'b0);
    hwdata_i = data;
    wait_ready_edge(resp, rdata, stalls);
    check_value("hresp_o", 32'(resp), 32'd0);
    check_value("write stall cycles", 32'(stalls), 32'd0);
    htrans_i = soc_pkg::IDLE;
    wait_ready_edge(resp, rdata, stalls);
    check_value("hresp_o", 32'(resp), 32'd0);
    check_value("read stall cycles", 32'(stalls), 32'd0);
    check_value("hrdata_o", rdata, data);
  endtask

  task automatic check_reset_state();
    check_value("hready_o", 32'(hready_o), 32'd1);
    check_value("hresp_o", 32'(hresp_o), 32'd0);
    check_value("gpio_out_o", gpio_out_o, 32'd0);
    check_value("gpio_oe_o", gpio_oe_o, 32'd0);
  endtask

  task automatic sram_random_rw();
    int unsigned idx_q[$];
    int unsigned idx;
    logic [31:0] data;
    logic [31:0] rdata;
    logic        resp;
    int          stalls;
    int          i;
    for (i = 0; i < SRAM_WRITES; i++) begin
      idx  = $urandom_range(`SRAM_DEPTH - 1, 0);
      data = $urandom();
      sram_model[idx] = data;
      idx_q.push_back(idx);
      ahb_write(`SRAM_BASE + (idx << 2), data, resp, stalls);
      check_value("hresp_o", 32'(resp), 32'd0);
      check_value("sram stall cycles", 32'(stalls), 32'd0);
    end
    foreach (idx_q[k]) begin
      ahb_read(`SRAM_BASE + (idx_q[k] << 2), rdata, resp, stalls);
      check_value("hresp_o", 32'(resp), 32'd0);
      check_value("sram stall cycles", 32'(stalls), 32'd0);
      check_value("hrdata_o", rdata, sram_model[idx_q[k]]);
    end
    idx  = $urandom_range(`SRAM_DEPTH - 1, 0);
    data = $urandom();
    sram_model[idx] = data;
    write_read_pipelined(`SRAM_BASE + (idx << 2), data);
    last_idx = idx;
  endtask

  task automatic gpio_out_dir();
    logic [31:0] out_val;
    logic [31:0] dir_val;
    logic [31:0] rdata;
    logic        resp;
    int          stalls;
    out_val = $urandom();
    dir_val = $urandom();
    ahb_write(`GPIO_BASE + 32'h0, out_val, resp, stalls);
    check_value("hresp_o", 32'(resp), 32'd0);
    check_value("gpio stall cycles", 32'(stalls), 32'd1);
    check_value("gpio_out_o", gpio_out_o, out_val);
    ahb_write(`GPIO_BASE + 32'h4, dir_val, resp, stalls);
    check_value("hresp_o", 32'(resp), 32'd0);
    check_value("gpio stall cycles", 32'(stalls), 32'd1);
    check_value("gpio_oe_o", gpio_oe_o, dir_val);
    ahb_read(`GPIO_BASE + 32'h0, rdata, resp, stalls);
    check_value("hresp_o", 32'(resp), 32'd0);
    check_value("gpio stall cycles", 32'(stalls), 32'd1);
    check_value("hrdata_o", rdata, out_val);
    ahb_read(`GPIO_BASE + 32'h4, rdata, resp, stalls);
    check_value("hresp_o", 32'(resp), 32'd0);
    check_value("gpio stall cycles", 32'(stalls), 32'd1);
    check_value("hrdata_o", rdata, dir_val);
  endtask

  task automatic gpio_input_sync();
    logic [31:0] in_val;
    logic [31:0] rdata;
    logic        resp;
    int          stalls;
    in_val    = $urandom();
    gpio_in_i = in_val;
    // Two synchronizer stages
    repeat (2) @(posedge core_clk);
    #1;
    ahb_read(`GPIO_BASE + 32'h8, rdata, resp, stalls);
    check_value("hresp_o", 32'(resp), 32'd0);
    check_value("hrdata_o", rdata, in_val);
  endtask

  task automatic error_responses();
    logic [31:0] out_before;
    logic [31:0] rdata;
    logic        resp;
    int          stalls;
    out_before = gpio_out_o;
    ahb_read(32'h2000_0000, rdata, resp, stalls);
    check_value("hresp_o", 32'(resp), 32'd1);
    check_value("unmapped stall cycles", 32'(stalls), 32'd1);
    ahb_write(`GPIO_BASE + 32'h8, ~out_before, resp, stalls);
    check_value("hresp_o", 32'(resp), 32'd1);
    check_value("gpio error stall cycles", 32'(stalls), 32'd2);
    check_value("gpio_out_o", gpio_out_o, out_before);
    ahb_read(`SRAM_BASE + (last_idx << 2), rdata, resp, stalls);
    check_value("hresp_o", 32'(resp), 32'd0);
    check_value("hrdata_o", rdata, sram_model[last_idx]);
  endtask

  initial begin
    seed      = $urandom(16933);
    reset_n   = 1'b0;
    haddr_i   = '0;
    htrans_i  = soc_pkg::IDLE;
    hwrite_i  = 1'b0;
    hwdata_i  = '0;
    gpio_in_i = '0;
    repeat (5) @(posedge core_clk);
    #1;
    reset_n = 1'b1;
    check_reset_state();
    sram_random_rw();
    gpio_out_dir();
    gpio_input_sync();
    error_responses();
    $display("Finished with no errors");
    $finish;
  end

endmodule
